// ==== Makefile ====
TOP = rename_tb

.PHONY: all build lint clean

# Build, run, then look for the pass line in the log
all: build
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "^STATUS: PASS$$" sim.log

build:
	verilator --binary --timing --assert -f rename.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f rename.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== bench/rename_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_checker (
    input logic                  clk,
    input logic                  reset,
    input logic                  dequeue_en,
    input logic                  enqueue_en,
    input logic                  was_dequeued,
    input logic                  was_enqueued,
    input rename_pkg::slot_idx_t head_ptr,
    input rename_pkg::slot_idx_t tail_ptr
);
    import rename_pkg::*;

    // Failed assertion tally
    int fail_count = 0;

    // Every enqueue acknowledged one cycle later
    enqueue_acked: assert property (@(posedge clk) disable iff (reset)
        enqueue_en |=> was_enqueued)
        else begin
            $error("enqueue_en was not followed by was_enqueued");
            fail_count++;
        end

    // Dequeue level only after a request
    dequeue_requested: assert property (@(posedge clk) disable iff (reset)
        was_dequeued |-> $past(dequeue_en))
        else begin
            $error("was_dequeued high without a prior dequeue_en");
            fail_count++;
        end

    // Both ring pointers stay inside the slot array
    pointers_in_range: assert property (@(posedge clk) disable iff (reset)
        (int'(head_ptr) < FREE_SLOTS) && (int'(tail_ptr) < FREE_SLOTS))
        else begin
            $error("free list pointer outside the slot range");
            fail_count++;
        end

endmodule

bind free_list rename_checker free_list_checks_i (
    .clk          (clk),
    .reset        (reset),
    .dequeue_en   (dequeue_en),
    .enqueue_en   (enqueue_en),
    .was_dequeued (was_dequeued),
    .was_enqueued (was_enqueued),
    .head_ptr     (head_ptr),
    .tail_ptr     (tail_ptr)
);

`default_nettype wire

// ==== bench/rename_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_tb;
    import rename_pkg::*;

    // Expected outcome of one rename request
    typedef struct packed {
        int unsigned due;
        logic        ok;
        phys_idx_t   src1;
        phys_idx_t   src2;
        phys_idx_t   dest;
        phys_idx_t   prev;
    } result_t;

    logic      clk;
    logic      reset;
    logic      rename_en;
    arch_idx_t rename_dest;
    arch_idx_t rename_src1;
    arch_idx_t rename_src2;
    logic      renamed;
    logic      rename_fail;
    phys_idx_t src1_pr;
    phys_idx_t src2_pr;
    phys_idx_t dest_pr;
    phys_idx_t prev_dest_pr;
    logic      commit_en;
    arch_idx_t commit_arch;
    phys_idx_t commit_pr;

    // Reference model of both maps and the free queue
    phys_idx_t   spec_map [ARCH_REGS];
    phys_idx_t   committed_map [ARCH_REGS];
    phys_idx_t   free_q [$];
    // Freed registers, with the first edge that may hand them out
    phys_idx_t   pend_pr [$];
    int unsigned pend_at [$];
    // Renamed, not yet committed
    arch_idx_t   inflight_arch [$];
    phys_idx_t   inflight_pr [$];
    result_t     exp_q [$];
    int          checked_ok;
    int          commits_sent;
    // Edges since the first request
    int unsigned cycle;
    logic [15:0] lfsr_state;
    string       test_name;

    rename_top rename_top_i (
        .clk          (clk),
        .reset        (reset),
        .rename_en    (rename_en),
        .rename_dest  (rename_dest),
        .rename_src1  (rename_src1),
        .rename_src2  (rename_src2),
        .renamed      (renamed),
        .rename_fail  (rename_fail),
        .src1_pr      (src1_pr),
        .src2_pr      (src2_pr),
        .dest_pr      (dest_pr),
        .prev_dest_pr (prev_dest_pr),
        .commit_en    (commit_en),
        .commit_arch  (commit_arch),
        .commit_pr    (commit_pr)
    );

    always #10 clk = ~clk;

    task automatic stop_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_pr(input string what, input phys_idx_t exp, input phys_idx_t act);
        if (act !== exp) begin
            $display("Error: %s %s expected %0d actual %0d", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s %s expected %b actual %b", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    function automatic int unsigned take_bits(input int n);
        int unsigned value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Drive one cycle of inputs and advance the model to match
    task automatic issue(input logic ren, input arch_idx_t d, input arch_idx_t s1,
                         input arch_idx_t s2, input logic com);
        result_t   exp;
        phys_idx_t freed;
        rename_en   = ren;
        rename_dest = d;
        rename_src1 = s1;
        rename_src2 = s2;
        commit_en   = com;
        if (com) begin
            if (checked_ok - commits_sent <= 0) begin
                $display("Test %s tried to commit with no completed rename", test_name);
                stop_with_failure();
            end
            commit_arch = inflight_arch.pop_front();
            commit_pr   = inflight_pr.pop_front();
            commits_sent++;
            // Displaced register reaches the queue two edges after the commit
            freed = committed_map[commit_arch];
            committed_map[commit_arch] = commit_pr;
            pend_pr.push_back(freed);
            pend_at.push_back(cycle + 3);
        end
        if (ren) begin
            while (pend_at.size() != 0 && pend_at[0] <= cycle + 1) begin
                free_q.push_back(pend_pr.pop_front());
                void'(pend_at.pop_front());
            end
            exp     = '0;
            exp.due = cycle + 2;
            exp.ok  = (free_q.size() != 0);
            if (exp.ok) begin
                exp.src1    = spec_map[s1];
                exp.src2    = spec_map[s2];
                exp.prev    = spec_map[d];
                exp.dest    = free_q.pop_front();
                spec_map[d] = exp.dest;
                inflight_arch.push_back(d);
                inflight_pr.push_back(exp.dest);
            end
            exp_q.push_back(exp);
        end
    endtask

    // Result pulses sampled mid-cycle
    task automatic check_results();
        result_t exp;
        if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
            exp = exp_q.pop_front();
            check_bit("renamed", exp.ok, renamed);
            check_bit("rename_fail", !exp.ok, rename_fail);
            if (exp.ok) begin
                check_pr("src1_pr", exp.src1, src1_pr);
                check_pr("src2_pr", exp.src2, src2_pr);
                check_pr("dest_pr", exp.dest, dest_pr);
                check_pr("prev_dest_pr", exp.prev, prev_dest_pr);
                checked_ok++;
            end
        end else if (renamed !== 1'b0 || rename_fail !== 1'b0) begin
            $display("Test %s saw a result pulse with no request due", test_name);
            stop_with_failure();
        end
    endtask

    task automatic step(input logic ren, input arch_idx_t d, input arch_idx_t s1,
                        input arch_idx_t s2, input logic com);
        issue(ren, d, s1, s2, com);
        @(negedge clk);
        check_results();
        @(posedge clk);
        #2;
        cycle++;
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == 10) begin
                $display("Test %s timed out waiting for rename results", test_name);
                stop_with_failure();
            end
            step(1'b0, '0, '0, '0, 1'b0);
            waited++;
        end
    endtask

    initial begin
        logic      ren;
        logic      com;
        arch_idx_t d;
        arch_idx_t s1;
        arch_idx_t s2;
        clk          = 1'b0;
        reset        = 1'b1;
        rename_en    = 1'b0;
        rename_dest  = '0;
        rename_src1  = '0;
        rename_src2  = '0;
        commit_en    = 1'b0;
        commit_arch  = '0;
        commit_pr    = '0;
        lfsr_state   = 16'd3;
        cycle        = 0;
        checked_ok   = 0;
        commits_sent = 0;
        // Identity maps, registers 8 to 15 free
        for (int i = 0; i < ARCH_REGS; i++) begin
            spec_map[i]      = phys_idx_t'(i);
            committed_map[i] = phys_idx_t'(i);
            free_q.push_back(phys_idx_t'(ARCH_REGS + i));
        end
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        test_name = "initial renames";
        for (int i = 0; i < ARCH_REGS; i++) begin
            step(1'b1, arch_idx_t'(i), arch_idx_t'(i), arch_idx_t'(i), 1'b0);
            wait_results();
        end

        test_name = "exhausted free list";
        step(1'b1, 3'd2, 3'd4, 3'd6, 1'b0);
        wait_results();

        test_name = "in-order commits";
        for (int i = 0; i < ARCH_REGS; i++) begin
            step(1'b0, '0, '0, '0, 1'b1);
        end

        // Each source hits the destination of the request before it
        test_name = "back-to-back forwarding";
        step(1'b1, 3'd3, 3'd1, 3'd2, 1'b0);
        step(1'b1, 3'd5, 3'd3, 3'd3, 1'b0);
        step(1'b1, 3'd3, 3'd3, 3'd5, 1'b0);
        step(1'b1, 3'd1, 3'd3, 3'd3, 1'b0);
        wait_results();

        test_name = "empty queue bypass";
        for (int i = 0; i < 16 && (free_q.size() + pend_pr.size()) != 0; i++) begin
            step(1'b1, arch_idx_t'(i), arch_idx_t'(i + 1), arch_idx_t'(i + 2), 1'b0);
        end
        wait_results();
        if (free_q.size() + pend_pr.size() != 0) begin
            $display("Free list still held registers before the bypass test");
            stop_with_failure();
        end
        // Enqueue and dequeue meet at the same edge
        step(1'b0, '0, '0, '0, 1'b1);
        step(1'b0, '0, '0, '0, 1'b0);
        step(1'b1, 3'd6, 3'd6, 3'd0, 1'b0);
        wait_results();

        test_name = "random mix";
        for (int n = 0; n < 1500; n++) begin
            ren = (take_bits(1) != 0);
            d   = arch_idx_t'(take_bits(3));
            s1  = arch_idx_t'(take_bits(3));
            s2  = arch_idx_t'(take_bits(3));
            com = (take_bits(1) != 0) && (checked_ok - commits_sent > 0);
            step(ren, d, s1, s2, com);
        end
        wait_results();

        if (rename_top_i.free_list_i.free_list_checks_i.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Free list assertions failed during the run");
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

// ==== rename.f ====
verilog/rename_pkg.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/rename_stage.sv
verilog/retire_stage.sv
verilog/rename_top.sv
bench/rename_checker.sv
bench/rename_tb.sv

// ==== verilog/free_list.sv ====
`timescale 1ns/100ps
`default_nettype none

module free_list (
    input  logic                  clk,
    input  logic                  reset,

    // Dequeue side, served from the tail
    input  logic                  dequeue_en,
    output rename_pkg::phys_idx_t dequeue_pr,
    output logic                  was_dequeued,

    // Enqueue side, written at the head
    input  logic                  enqueue_en,
    input  rename_pkg::phys_idx_t enqueue_pr,
    output logic                  was_enqueued
);
    import rename_pkg::*;

    // Ring of free physical register numbers
    phys_idx_t slots [FREE_SLOTS];

    // Head is the next slot to fill
    slot_idx_t head_ptr;
    // Tail is the oldest filled slot
    slot_idx_t tail_ptr;

    logic      is_empty;
    logic      is_full;
    slot_idx_t head_next;
    slot_idx_t tail_next;

    // Advance with wrap at the last slot
    function automatic slot_idx_t next_slot(input slot_idx_t ptr);
        slot_idx_t result;
        if (ptr == slot_idx_t'(FREE_SLOTS - 1)) begin
            result = '0;
        end else begin
            result = ptr + slot_idx_t'(1);
        end
        return result;
    endfunction

    assign head_next = next_slot(head_ptr);
    assign tail_next = next_slot(tail_ptr);

    assign is_empty = (head_ptr == tail_ptr);
    assign is_full  = (head_next == tail_ptr);

    always_ff @(posedge clk) begin
        if (reset) begin
            // Registers above the identity block start free, lowest first
            for (int i = 0; i < PHYS_REGS - ARCH_REGS; i++) begin
                slots[i] <= phys_idx_t'(ARCH_REGS + i);
            end
            tail_ptr     <= '0;
            head_ptr     <= slot_idx_t'(PHYS_REGS - ARCH_REGS);
            was_dequeued <= 1'b0;
            was_enqueued <= 1'b0;
        end else if (dequeue_en && enqueue_en && is_empty) begin
            // Nothing stored, hand the freed number straight over
            dequeue_pr   <= enqueue_pr;
            was_dequeued <= 1'b1;
            was_enqueued <= 1'b1;
        end else begin
            // Oldest entry out
            if (dequeue_en && !is_empty) begin
                dequeue_pr   <= slots[tail_ptr];
                tail_ptr     <= tail_next;
                was_dequeued <= 1'b1;
            end else begin
                was_dequeued <= 1'b0;
            end

            // New entry in, refused only when full with no dequeue
            if (enqueue_en && (!is_full || dequeue_en)) begin
                slots[head_ptr] <= enqueue_pr;
                head_ptr        <= head_next;
                was_enqueued    <= 1'b1;
            end else begin
                was_enqueued <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/map_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module map_table (
    input  logic                  clk,
    input  logic                  reset,

    // Lookup ports, answered in the same cycle
    input  rename_pkg::arch_idx_t rd_arch1,
    input  rename_pkg::arch_idx_t rd_arch2,
    input  rename_pkg::arch_idx_t rd_arch3,
    output rename_pkg::phys_idx_t rd_pr1,
    output rename_pkg::phys_idx_t rd_pr2,
    output rename_pkg::phys_idx_t rd_pr3,

    // Update port, lands at the next edge
    input  logic                  map_we,
    input  rename_pkg::arch_idx_t map_arch,
    input  rename_pkg::phys_idx_t map_pr
);
    import rename_pkg::*;

    // Speculative architectural to physical mapping
    phys_idx_t spec_map [ARCH_REGS];

    // Reads see the stored value only
    // A write in flight is bypassed by the rename stage
    assign rd_pr1 = spec_map[rd_arch1];
    assign rd_pr2 = spec_map[rd_arch2];
    assign rd_pr3 = spec_map[rd_arch3];

    always_ff @(posedge clk) begin
        if (reset) begin
            // Identity map out of reset
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_map[i] <= phys_idx_t'(i);
            end
        end else if (map_we) begin
            spec_map[map_arch] <= map_pr;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // Architectural register count
    localparam int ARCH_REGS = 8;

    // Physical register count
    localparam int PHYS_REGS = 16;

    // One spare slot keeps full distinct from empty
    localparam int FREE_SLOTS = PHYS_REGS - ARCH_REGS + 1;

    // Architectural register index
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_idx_t;

    // Physical register index
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_idx_t;

    // Free list slot pointer
    typedef logic [$clog2(FREE_SLOTS)-1:0] slot_idx_t;

endpackage

`default_nettype wire

// ==== verilog/rename_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_stage (
    input  logic                  clk,
    input  logic                  reset,

    // Rename request strobe
    input  logic                  rename_en,
    input  rename_pkg::arch_idx_t rename_dest,
    input  rename_pkg::arch_idx_t rename_src1,
    input  rename_pkg::arch_idx_t rename_src2,

    // Free list
    output logic                  dequeue_en,
    input  rename_pkg::phys_idx_t dequeue_pr,
    input  logic                  was_dequeued,

    // Map table lookups
    output rename_pkg::arch_idx_t map_rd_dest,
    output rename_pkg::arch_idx_t map_rd_src1,
    output rename_pkg::arch_idx_t map_rd_src2,
    input  rename_pkg::phys_idx_t dest_map,
    input  rename_pkg::phys_idx_t src1_map,
    input  rename_pkg::phys_idx_t src2_map,

    // Map table update
    output logic                  map_we,
    output rename_pkg::arch_idx_t map_arch,
    output rename_pkg::phys_idx_t map_pr,

    // Results, one cycle after the request is taken
    output logic                  renamed,
    output logic                  rename_fail,
    output rename_pkg::phys_idx_t src1_pr,
    output rename_pkg::phys_idx_t src2_pr,
    output rename_pkg::phys_idx_t dest_pr,
    output rename_pkg::phys_idx_t prev_dest_pr
);
    import rename_pkg::*;

    // Request waiting on the free list answer
    logic      req_valid;
    arch_idx_t req_dest;
    arch_idx_t req_src1;
    arch_idx_t req_src2;
    phys_idx_t req_src1_pr;
    phys_idx_t req_src2_pr;
    phys_idx_t req_prev_pr;

    // Lookups with the pending map write applied
    phys_idx_t look_src1;
    phys_idx_t look_src2;
    phys_idx_t look_dest;

    // Free list samples at the same edge as the request
    assign dequeue_en  = rename_en;
    assign map_rd_dest = rename_dest;
    assign map_rd_src1 = rename_src1;
    assign map_rd_src2 = rename_src2;

    // A successful result writes its mapping in its output cycle
    assign map_we = renamed;
    assign map_pr = dest_pr;

    // Write in flight lands at this same edge, so the table is still stale
    always_comb begin
        look_src1 = src1_map;
        look_src2 = src2_map;
        look_dest = dest_map;
        if (map_we && map_arch == rename_src1) look_src1 = map_pr;
        if (map_we && map_arch == rename_src2) look_src2 = map_pr;
        if (map_we && map_arch == rename_dest) look_dest = map_pr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= rename_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rename_en) begin
            req_dest    <= rename_dest;
            req_src1    <= rename_src1;
            req_src2    <= rename_src2;
            req_src1_pr <= look_src1;
            req_src2_pr <= look_src2;
            req_prev_pr <= look_dest;
        end
    end

    // Pulse per request, success only when a register came out
    always_ff @(posedge clk) begin
        if (reset) begin
            renamed     <= 1'b0;
            rename_fail <= 1'b0;
        end else begin
            renamed     <= req_valid && was_dequeued;
            rename_fail <= req_valid && !was_dequeued;
        end
    end

    // Back-to-back case: the previous result is still in the output register
    always_ff @(posedge clk) begin
        if (req_valid) begin
            map_arch     <= req_dest;
            dest_pr      <= dequeue_pr;
            src1_pr      <= (renamed && map_arch == req_src1) ? dest_pr : req_src1_pr;
            src2_pr      <= (renamed && map_arch == req_src2) ? dest_pr : req_src2_pr;
            prev_dest_pr <= (renamed && map_arch == req_dest) ? dest_pr : req_prev_pr;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rename_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_top (
    input  logic                  clk,
    input  logic                  reset,

    // Rename request and results
    input  logic                  rename_en,
    input  rename_pkg::arch_idx_t rename_dest,
    input  rename_pkg::arch_idx_t rename_src1,
    input  rename_pkg::arch_idx_t rename_src2,
    output logic                  renamed,
    output logic                  rename_fail,
    output rename_pkg::phys_idx_t src1_pr,
    output rename_pkg::phys_idx_t src2_pr,
    output rename_pkg::phys_idx_t dest_pr,
    output rename_pkg::phys_idx_t prev_dest_pr,

    // Commit
    input  logic                  commit_en,
    input  rename_pkg::arch_idx_t commit_arch,
    input  rename_pkg::phys_idx_t commit_pr
);
    import rename_pkg::*;

    // Rename stage to free list
    logic      dequeue_en;
    phys_idx_t dequeue_pr;
    logic      was_dequeued;

    // Retire stage to free list
    logic      enqueue_en;
    phys_idx_t enqueue_pr;

    // Rename stage to map table
    arch_idx_t map_rd_dest;
    arch_idx_t map_rd_src1;
    arch_idx_t map_rd_src2;
    phys_idx_t dest_map;
    phys_idx_t src1_map;
    phys_idx_t src2_map;
    logic      map_we;
    arch_idx_t map_arch;
    phys_idx_t map_pr;

    rename_stage rename_stage_i (
        .clk          (clk),
        .reset        (reset),
        .rename_en    (rename_en),
        .rename_dest  (rename_dest),
        .rename_src1  (rename_src1),
        .rename_src2  (rename_src2),
        .dequeue_en   (dequeue_en),
        .dequeue_pr   (dequeue_pr),
        .was_dequeued (was_dequeued),
        .map_rd_dest  (map_rd_dest),
        .map_rd_src1  (map_rd_src1),
        .map_rd_src2  (map_rd_src2),
        .dest_map     (dest_map),
        .src1_map     (src1_map),
        .src2_map     (src2_map),
        .map_we       (map_we),
        .map_arch     (map_arch),
        .map_pr       (map_pr),
        .renamed      (renamed),
        .rename_fail  (rename_fail),
        .src1_pr      (src1_pr),
        .src2_pr      (src2_pr),
        .dest_pr      (dest_pr),
        .prev_dest_pr (prev_dest_pr)
    );

    // Port 3 serves the destination lookup
    map_table map_table_i (
        .clk      (clk),
        .reset    (reset),
        .rd_arch1 (map_rd_src1),
        .rd_arch2 (map_rd_src2),
        .rd_arch3 (map_rd_dest),
        .rd_pr1   (src1_map),
        .rd_pr2   (src2_map),
        .rd_pr3   (dest_map),
        .map_we   (map_we),
        .map_arch (map_arch),
        .map_pr   (map_pr)
    );

    retire_stage retire_stage_i (
        .clk         (clk),
        .reset       (reset),
        .commit_en   (commit_en),
        .commit_arch (commit_arch),
        .commit_pr   (commit_pr),
        .enqueue_en  (enqueue_en),
        .enqueue_pr  (enqueue_pr)
    );

    // Enqueue acknowledge has no consumer, the queue cannot overflow
    free_list free_list_i (
        .clk          (clk),
        .reset        (reset),
        .dequeue_en   (dequeue_en),
        .dequeue_pr   (dequeue_pr),
        .was_dequeued (was_dequeued),
        .enqueue_en   (enqueue_en),
        .enqueue_pr   (enqueue_pr),
        .was_enqueued ()
    );

endmodule

`default_nettype wire

// ==== verilog/retire_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module retire_stage (
    input  logic                  clk,
    input  logic                  reset,

    // Commit strobe, in rename order
    input  logic                  commit_en,
    input  rename_pkg::arch_idx_t commit_arch,
    input  rename_pkg::phys_idx_t commit_pr,

    // Displaced register back to the free list
    output logic                  enqueue_en,
    output rename_pkg::phys_idx_t enqueue_pr
);
    import rename_pkg::*;

    // Architectural state as of the last commit
    phys_idx_t committed_map [ARCH_REGS];

    // Commit held one cycle before the map lookup
    logic      commit_valid;
    arch_idx_t commit_arch_q;
    phys_idx_t commit_pr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= commit_en;
        end
    end

    always_ff @(posedge clk) begin
        if (commit_en) begin
            commit_arch_q <= commit_arch;
            commit_pr_q   <= commit_pr;
        end
    end

    // Lookup and overwrite in one edge, so consecutive commits chain
    always_ff @(posedge clk) begin
        if (reset) begin
            enqueue_en <= 1'b0;
            for (int i = 0; i < ARCH_REGS; i++) begin
                committed_map[i] <= phys_idx_t'(i);
            end
        end else begin
            enqueue_en <= commit_valid;
            if (commit_valid) begin
                committed_map[commit_arch_q] <= commit_pr_q;
            end
        end
    end

    // Old committed register is now unreachable
    always_ff @(posedge clk) begin
        if (commit_valid) begin
            enqueue_pr <= committed_map[commit_arch_q];
        end
    end

endmodule

`default_nettype wire
